// ==== rtl/config_regs.sv ====
// register stage for the configuration word, joystick words and 64-bit status
`timescale 1ns/1ps

module config_regs
	import host_bridge_pkg::*;
(
	input  logic                         clk_sys,
	input  logic                         reset,

	// framed word from io_frame
	input  logic                         word_valid,
	input  cmd_t                         word_cmd,
	input  word_index_t                  word_index,
	input  word_t                        word_data,

	// core side registers
	output logic [cfg_buttons_width-1:0] buttons,
	output logic                         forced_scandoubler,
	output logic                         direct_video,
	output joy_t                         joystick_0,
	output joy_t                         joystick_1,
	output status_t                      status
);

	word_t cfg;
	logic  param_word;

	// only words after the command carry register data
	assign param_word = word_valid && (word_index != '0);

	// fields of the cfg word
	assign buttons            = cfg[cfg_buttons_lsb +: cfg_buttons_width];
	assign forced_scandoubler = cfg[cfg_scandoubler_bit];
	assign direct_video       = cfg[cfg_direct_video_bit];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (param_word) begin
			case (word_cmd)
				// every parameter word overwrites so the last one wins
				cmd_cfg: cfg <= word_data;

				// low half at word 1 and anything later to the high half
				cmd_joy0: begin
					if (word_index == 10'd1) joystick_0[15:0] <= word_data;
					else joystick_0[31:16] <= word_data;
				end
				cmd_joy1: begin
					if (word_index == 10'd1) joystick_1[15:0] <= word_data;
					else joystick_1[31:16] <= word_data;
				end

				// four slices with word 1 the lowest
				cmd_status: begin
					case (word_index)
						10'd1: status[15:0]  <= word_data;
						10'd2: status[31:16] <= word_data;
						10'd3: status[47:32] <= word_data;
						10'd4: status[63:48] <= word_data;
						default: ;
					endcase
				end

				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/file_download.sv ====
// download command stage with the running address and write strobe generation
`timescale 1ns/1ps

module file_download
	import host_bridge_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	// framed word from io_frame
	input  logic        word_valid,
	input  cmd_t        word_cmd,
	input  word_index_t word_index,
	input  word_t       word_data,

	// download port towards the core
	output logic        ioctl_download,
	output logic [7:0]  ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output word_t       ioctl_dout,
	output logic [31:0] ioctl_file_ext
);

	// address of the next data word
	ioctl_addr_t addr;
	logic        param_word;

	assign param_word = word_valid && (word_index != '0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
			addr           <= '0;
		end else begin
			// single cycle write pulse
			ioctl_wr <= 1'b0;

			if (param_word) begin
				case (word_cmd)
					// extension arrives upper half first
					cmd_file_info: begin
						if (word_index == 10'd1) ioctl_file_ext[31:16] <= word_data;
						if (word_index == 10'd2) ioctl_file_ext[15:0]  <= word_data;
					end

					cmd_file_index: ioctl_index <= word_data[7:0];

					// a non-zero byte starts a download and zero ends it
					cmd_file_tx: begin
						if (word_data[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end

					cmd_file_tx_dat: begin
						ioctl_addr <= addr;
						ioctl_dout <= word_data;
						ioctl_wr   <= 1'b1;
						addr       <= addr + ioctl_addr_step;
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// ==== rtl/host_bridge.sv ====
// top level wiring the framing stage to the register, download and reply stages
`timescale 1ns/1ps

module host_bridge
	import host_bridge_pkg::*;
(
	input  logic                         clk_sys,
	input  logic                         reset,

	// host word channel
	input  logic                         io_enable,
	input  logic                         io_strobe,
	input  word_t                        io_din,
	output word_t                        io_dout,

	// core side inputs
	input  status_t                      status_in,
	input  logic                         status_set,
	input  word_t                        uart_mode,

	// configuration and joysticks
	output logic [cfg_buttons_width-1:0] buttons,
	output logic                         forced_scandoubler,
	output logic                         direct_video,
	output joy_t                         joystick_0,
	output joy_t                         joystick_1,
	output status_t                      status,

	// file download
	output logic                         ioctl_download,
	output logic [7:0]                   ioctl_index,
	output logic                         ioctl_wr,
	output ioctl_addr_t                  ioctl_addr,
	output word_t                        ioctl_dout,
	output logic [31:0]                  ioctl_file_ext
);

	logic        frame_active;
	logic        word_valid;
	cmd_t        word_cmd;
	word_index_t word_index;
	word_t       word_data;

	io_frame io_frame_i (
		.clk_sys(clk_sys), .reset(reset),
		.io_enable(io_enable), .io_strobe(io_strobe), .io_din(io_din),
		.frame_active(frame_active), .word_valid(word_valid),
		.word_cmd(word_cmd), .word_index(word_index), .word_data(word_data)
	);

	config_regs config_regs_i (
		.clk_sys(clk_sys), .reset(reset),
		.word_valid(word_valid), .word_cmd(word_cmd),
		.word_index(word_index), .word_data(word_data),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.direct_video(direct_video), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status)
	);

	file_download file_download_i (
		.clk_sys(clk_sys), .reset(reset),
		.word_valid(word_valid), .word_cmd(word_cmd),
		.word_index(word_index), .word_data(word_data),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_file_ext(ioctl_file_ext)
	);

	status_readback status_readback_i (
		.clk_sys(clk_sys), .reset(reset),
		.frame_active(frame_active), .word_valid(word_valid),
		.word_cmd(word_cmd), .word_index(word_index),
		.status_in(status_in), .status_set(status_set),
		.uart_mode(uart_mode), .io_dout(io_dout)
	);

endmodule

// ==== rtl/host_bridge_pkg.sv ====
// word types, command codes, reply marker and cfg field positions of the host bridge
package host_bridge_pkg;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	// one word of the host channel
	typedef logic [15:0] word_t;
	// command code carried by the first word of a frame
	typedef logic [15:0] cmd_t;
	// word position inside a frame that saturates at all ones
	typedef logic [9:0]  word_index_t;
	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	// download byte address
	typedef logic [26:0] ioctl_addr_t;

	//////////////////////////////////////////////////
	// command codes
	//////////////////////////////////////////////////

	localparam cmd_t cmd_cfg         = 16'h0001;
	localparam cmd_t cmd_joy0        = 16'h0002;
	localparam cmd_t cmd_joy1        = 16'h0003;
	localparam cmd_t cmd_status      = 16'h001E;
	localparam cmd_t cmd_uart_mode   = 16'h0028;
	localparam cmd_t cmd_status_req  = 16'h0029;

	// file download group
	localparam cmd_t cmd_file_tx     = 16'h0053;
	localparam cmd_t cmd_file_tx_dat = 16'h0054;
	localparam cmd_t cmd_file_index  = 16'h0055;
	localparam cmd_t cmd_file_info   = 16'h0056;

	//////////////////////////////////////////////////
	// reply and download constants
	//////////////////////////////////////////////////

	// upper nibble of the status request reply byte
	localparam logic [3:0] status_req_marker = 4'hA;

	// 16-bit data words advance the address by two bytes
	localparam ioctl_addr_t ioctl_addr_step = 27'd2;

	// cfg word layout
	localparam int cfg_buttons_lsb      = 0;
	localparam int cfg_buttons_width    = 2;
	localparam int cfg_scandoubler_bit  = 4;
	localparam int cfg_direct_video_bit = 10;

endpackage

// ==== rtl/io_frame.sv ====
// framing stage that latches the command and numbers the words of each frame
`timescale 1ns/1ps

module io_frame
	import host_bridge_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	// host word channel
	input  logic        io_enable,
	input  logic        io_strobe,
	input  word_t       io_din,

	// framed word towards the later stages
	output logic        frame_active,
	output logic        word_valid,
	output cmd_t        word_cmd,
	output word_index_t word_index,
	output word_t       word_data
);

	// position of the next word in the current frame
	word_index_t word_cnt;
	// command of the current frame
	cmd_t        cmd_latched;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			frame_active <= 1'b0;
			word_valid   <= 1'b0;
			word_cmd     <= '0;
			word_index   <= '0;
			word_data    <= '0;
			word_cnt     <= '0;
			cmd_latched  <= '0;
		end else begin
			frame_active <= io_enable;
			word_valid   <= io_enable & io_strobe;

			if (!io_enable) begin
				word_cnt <= '0;
			end else if (io_strobe) begin
				word_index <= word_cnt;
				word_data  <= io_din;

				// word 0 is the command itself
				if (word_cnt == '0) begin
					cmd_latched <= io_din;
					word_cmd    <= io_din;
				end else begin
					word_cmd <= cmd_latched;
				end

				// hold at all ones on very long frames
				if (~&word_cnt) begin
					word_cnt <= word_cnt + 10'd1;
				end
			end
		end
	end

endmodule

// ==== rtl/status_readback.sv ====
// status-set request capture with its change counter and the host reply word
`timescale 1ns/1ps

module status_readback
	import host_bridge_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,

	// framed word from io_frame
	input  logic        frame_active,
	input  logic        word_valid,
	input  cmd_t        word_cmd,
	input  word_index_t word_index,

	// core side request and flags
	input  status_t     status_in,
	input  logic        status_set,
	input  word_t       uart_mode,

	output word_t       io_dout
);

	//////////////////////////////////////////////////
	// status-set request capture
	//////////////////////////////////////////////////

	logic       status_set_r;
	logic       status_set_old;
	logic [3:0] change_cnt;
	status_t    status_req;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_r   <= 1'b0;
			status_set_old <= 1'b0;
			change_cnt     <= '0;
			status_req     <= '0;
		end else begin
			status_set_r   <= status_set;
			status_set_old <= status_set_r;
			// rising edge after the input register
			if (status_set_r && !status_set_old) begin
				status_req <= status_in;
				change_cnt <= change_cnt + 4'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// reply word
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (!frame_active) begin
			io_dout <= '0;
		end else if (word_valid) begin
			// unknown commands answer zero
			io_dout <= '0;
			case (word_cmd)
				cmd_status_req: begin
					case (word_index)
						10'd0: io_dout <= {8'h00, status_req_marker, change_cnt};
						10'd1: io_dout <= status_req[15:0];
						10'd2: io_dout <= status_req[31:16];
						10'd3: io_dout <= status_req[47:32];
						10'd4: io_dout <= status_req[63:48];
						default: ;
					endcase
				end
				cmd_uart_mode: begin
					if (word_index != '0) io_dout <= uart_mode;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the host bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_host_bridge -f verilog.f -o sim_host_bridge
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_host_bridge > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== testbench/host_bridge_checker.sv ====
// reference model of the bridge with reply and write comparison, test counts and timeout
`timescale 1ns/1ps

module host_bridge_checker
	import host_bridge_pkg::*;
#(
	parameter int cycle_limit = 1000
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        io_enable,
	input  logic        io_strobe,
	input  word_t       io_din,
	input  word_t       io_dout,
	input  status_t     status_in,
	input  logic        status_set,
	input  word_t       uart_mode,
	input  logic [1:0]  buttons,
	input  logic        forced_scandoubler,
	input  logic        direct_video,
	input  joy_t        joystick_0,
	input  joy_t        joystick_1,
	input  status_t     status,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  ioctl_addr_t ioctl_addr,
	input  word_t       ioctl_dout,
	input  logic [31:0] ioctl_file_ext,
	input  logic        check_req,
	input  int          test_id,
	output int          error_count,
	output int          test_count,
	output logic        timed_out
);

	// model state updated from the host words as they are strobed
	word_index_t m_cnt;
	cmd_t        m_cmd;
	word_t       m_cfg;
	joy_t        m_joy0, m_joy1;
	status_t     m_status, m_req;
	logic [3:0]  m_changes;
	logic        m_set_prev, m_download;
	logic [7:0]  m_index;
	logic [31:0] m_ext;
	ioctl_addr_t m_addr_run, m_addr_out;
	word_t       m_dout;
	logic [42:0] wr_q[$];
	logic [1:0]  rp_valid;
	word_t       rp_word[2];
	int          test_errors;
	int          cycles;

	function automatic joy_t joy_write(joy_t j, word_index_t idx, word_t d);
		if (idx == 10'd1) return {j[31:16], d};
		return {d, j[15:0]};
	endfunction

	function automatic status_t status_write(status_t s, word_index_t idx, word_t d);
		status_t r;
		r = s;
		if (idx >= 10'd1 && idx <= 10'd4) r[(idx - 10'd1) * 16 +: 16] = d;
		return r;
	endfunction

	// expected reply for one word of a frame
	function automatic word_t reply_word(cmd_t c, word_index_t idx, logic [3:0] n, status_t req,
			word_t uart);
		if (c == cmd_status_req && idx == 10'd0) return {8'h00, 4'hA, n};
		if (c == cmd_status_req && idx <= 10'd4) return req[(idx - 10'd1) * 16 +: 16];
		if (c == cmd_uart_mode && idx != 10'd0) return uart;
		return 16'h0000;
	endfunction

	function automatic string test_name(int id);
		case (id)
			1: return "cfg word";
			2: return "joysticks back to back";
			3: return "status word";
			4: return "status request and uart mode";
			5: return "download started";
			6: return "download ended";
			default: return "unknown command";
		endcase
	endfunction

	task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			$display("error %s: got %h expected %h", name, got, exp);
			error_count++;
			test_errors++;
		end
	endtask

	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			m_cnt = '0;
			m_cmd = '0;
			m_cfg = '0;
			m_joy0 = '0;
			m_joy1 = '0;
			m_status = '0;
			m_req = '0;
			m_changes = '0;
			m_set_prev = 1'b0;
			m_download = 1'b0;
			m_index = '0;
			m_ext = '0;
			m_addr_run = '0;
			m_addr_out = '0;
			m_dout = '0;
			rp_valid = '0;
			wr_q.delete();
			error_count = 0;
			test_count = 0;
			test_errors = 0;
			cycles = 0;
			timed_out = 1'b0;
		end else begin
			cycles++;
			if (cycles >= cycle_limit) timed_out = 1'b1;

			// reply of a word shows two cycles after its strobe
			if (rp_valid[1]) check_val("io_dout", 64'(io_dout), 64'(rp_word[1]));
			rp_valid[1] = rp_valid[0];
			rp_word[1]  = rp_word[0];
			rp_valid[0] = 1'b0;

			if (ioctl_wr) begin
				if (wr_q.size() == 0) begin
					$display("unexpected ioctl_wr pulse with no data word sent");
					error_count++;
					test_errors++;
				end else begin
					logic [42:0] w;
					w = wr_q.pop_front();
					check_val("ioctl_addr", 64'(ioctl_addr), 64'(w[42:16]));
					check_val("ioctl_dout", 64'(ioctl_dout), 64'(w[15:0]));
				end
			end

			if (status_set && !m_set_prev) begin
				m_req = status_in;
				m_changes = m_changes + 4'd1;
			end
			m_set_prev = status_set;

			if (!io_enable) begin
				m_cnt = '0;
			end else if (io_strobe) begin
				if (m_cnt == 10'd0) m_cmd = io_din;
				rp_valid[0] = 1'b1;
				rp_word[0] = reply_word(m_cmd, m_cnt, m_changes, m_req, uart_mode);
				if (m_cnt != 10'd0) begin
					case (m_cmd)
						cmd_cfg:        m_cfg = io_din;
						cmd_joy0:       m_joy0 = joy_write(m_joy0, m_cnt, io_din);
						cmd_joy1:       m_joy1 = joy_write(m_joy1, m_cnt, io_din);
						cmd_status:     m_status = status_write(m_status, m_cnt, io_din);
						cmd_file_index: m_index = io_din[7:0];
						cmd_file_info: begin
							if (m_cnt == 10'd1) m_ext[31:16] = io_din;
							if (m_cnt == 10'd2) m_ext[15:0] = io_din;
						end
						cmd_file_tx: begin
							m_download = (io_din[7:0] != 8'h00);
							if (m_download) m_addr_run = '0;
							else m_addr_out = m_addr_run;
						end
						cmd_file_tx_dat: begin
							wr_q.push_back({m_addr_run, io_din});
							m_addr_out = m_addr_run;
							m_dout = io_din;
							m_addr_run = m_addr_run + 27'd2;
						end
						default: ;
					endcase
				end
				if (~&m_cnt) m_cnt = m_cnt + 10'd1;
			end

			if (check_req) begin
				check_val("buttons", 64'(buttons), 64'(m_cfg[1:0]));
				check_val("forced_scandoubler", 64'(forced_scandoubler), 64'(m_cfg[4]));
				check_val("direct_video", 64'(direct_video), 64'(m_cfg[10]));
				check_val("joystick_0", 64'(joystick_0), 64'(m_joy0));
				check_val("joystick_1", 64'(joystick_1), 64'(m_joy1));
				check_val("status", status, m_status);
				check_val("ioctl_download", 64'(ioctl_download), 64'(m_download));
				check_val("ioctl_index", 64'(ioctl_index), 64'(m_index));
				check_val("ioctl_file_ext", 64'(ioctl_file_ext), 64'(m_ext));
				check_val("ioctl_addr", 64'(ioctl_addr), 64'(m_addr_out));
				check_val("ioctl_dout", 64'(ioctl_dout), 64'(m_dout));
				// reply is back at zero once the frame is over
				check_val("io_dout", 64'(io_dout), 64'h0);
				if (wr_q.size() != 0) begin
					$display("missing ioctl_wr pulses: %0d data words not written", wr_q.size());
					error_count++;
					test_errors++;
				end
				$display("test %0d %s: %s", test_id, test_name(test_id),
					(test_errors == 0) ? "ok" : "errors");
				test_count++;
				test_errors = 0;
			end
		end
	end

endmodule

// ==== testbench/tb_host_bridge.sv ====
// clock, reset, host frame tasks, DUT and checker instances
`timescale 1ns/1ps

module tb_host_bridge
	import host_bridge_pkg::*;
();

	localparam int settle_cycles = 4;
	// frame cycles per test including gaps and settle time
	localparam int frame_cycles = 30 + 24 + 20 + 70 + 50 + 12;
	localparam int cycle_limit  = 2 * frame_cycles + 200;

	logic        clk_sys, reset, io_enable, io_strobe, status_set, check_req;
	word_t       io_din, io_dout, uart_mode, ioctl_dout;
	status_t     status_in, status;
	logic [1:0]  buttons;
	logic        forced_scandoubler, direct_video, ioctl_download, ioctl_wr, timed_out;
	joy_t        joystick_0, joystick_1;
	logic [7:0]  ioctl_index;
	ioctl_addr_t ioctl_addr;
	logic [31:0] ioctl_file_ext;
	int          test_id, error_count, test_count;
	word_t       frame_q[$];

	host_bridge dut_i (.*);

	host_bridge_checker #(.cycle_limit(cycle_limit)) checker_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	function automatic word_t rand_word();
		return word_t'($urandom());
	endfunction

	// sends frame_q as one frame with gap idle cycles after each strobe
	task automatic send_frame(int gap);
		@(posedge clk_sys);
		io_enable <= 1'b1;
		foreach (frame_q[i]) begin
			@(posedge clk_sys);
			io_strobe <= 1'b1;
			io_din    <= frame_q[i];
			repeat (gap) begin
				@(posedge clk_sys);
				io_strobe <= 1'b0;
			end
		end
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(posedge clk_sys);
		io_enable <= 1'b0;
	endtask

	task automatic pulse_status_set();
		@(posedge clk_sys);
		status_in <= {$urandom(), $urandom()};
		@(posedge clk_sys);
		status_set <= 1'b1;
		repeat (2) @(posedge clk_sys);
		status_set <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic checkpoint(int id);
		repeat (settle_cycles) @(posedge clk_sys);
		test_id   <= id;
		check_req <= 1'b1;
		@(posedge clk_sys);
		check_req <= 1'b0;
		@(posedge clk_sys);
	endtask

	always @(posedge clk_sys) begin
		if (timed_out) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		void'($urandom(47));
		reset = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		uart_mode = '0;
		check_req = 1'b0;
		test_id = 0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;

		frame_q = {cmd_cfg};
		repeat (6) frame_q.push_back(rand_word());
		send_frame(2);
		checkpoint(1);

		frame_q = {cmd_joy0, rand_word(), rand_word()};
		send_frame(0);
		frame_q = {cmd_joy1, rand_word(), rand_word()};
		send_frame(0);
		checkpoint(2);

		frame_q = {cmd_status, rand_word(), rand_word(), rand_word(), rand_word()};
		send_frame(1);
		checkpoint(3);

		repeat (5) pulse_status_set();
		uart_mode <= rand_word();
		frame_q = {cmd_status_req, 16'h0, 16'h0, 16'h0, 16'h0};
		send_frame(1);
		frame_q = {cmd_uart_mode, 16'h0, 16'h0};
		send_frame(0);
		checkpoint(4);

		frame_q = {cmd_file_info, rand_word(), rand_word()};
		send_frame(1);
		frame_q = {cmd_file_index, rand_word()};
		send_frame(0);
		frame_q = {cmd_file_tx, 16'h0001};
		send_frame(0);
		checkpoint(5);
		frame_q = {cmd_file_tx_dat};
		repeat (8) frame_q.push_back(rand_word());
		send_frame(0);
		frame_q = {cmd_file_tx, 16'h0000};
		send_frame(0);
		checkpoint(6);

		frame_q = {16'h00F0, rand_word(), rand_word()};
		send_frame(1);
		checkpoint(7);

		$display("tests run %0d, errors %0d", test_count, error_count);
		if (error_count == 0 && test_count == 7) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/host_bridge_pkg.sv
rtl/io_frame.sv
rtl/config_regs.sv
rtl/file_download.sv
rtl/status_readback.sv
rtl/host_bridge.sv
testbench/host_bridge_checker.sv
testbench/tb_host_bridge.sv
